//--- design/side_delay_line.sv
`timescale 1ns/100ps

module side_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  payload_t  in_i,
  output payload_t  out_o
);

  // ----------------------------------------
  // Shift line
  // ----------------------------------------
  // Entry 0 takes the input, last entry drives the output
  payload_t [DEPTH-1:0] line_q;

  // Cleared on reset so any strobe in the payload starts low
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_q <= '0;
    end else begin
      line_q[0] <= in_i;
      // Each entry moves one step per cycle
      for (int i = 1; i < DEPTH; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  assign out_o = line_q[DEPTH-1];

endmodule

//--- design/solinas_cfg.svh
`ifndef SOLINAS_CFG_SVH
`define SOLINAS_CFG_SVH

// ----------------------------------------
// Modulus M = 2^32 - 2^21 - 2^10 + 1
// ----------------------------------------

// Result width, also the outer power of M
`define SOLINAS_MOD_W 32

// Operand width, sum of two 64-bit products
`define SOLINAS_OP_W 65

// Inner powers of the modulus
`define SOLINAS_POW_HI 21
`define SOLINAS_POW_LO 10

// Modulus value
`define SOLINAS_MOD_M 32'hFFDF_FC01

// Side tag carried next to each operand
`define SOLINAS_SIDE_W 8

// ----------------------------------------
// Internal widths and timing
// ----------------------------------------

// Signed fold sum, holds -2M up to 4M
`define SOLINAS_SUM_W 35

// Sum of the carry bits of both inner partial sums
`define SOLINAS_WRAP_W 3

// Input register + 4 stage registers
`define SOLINAS_LATENCY 5

`endif

//--- design/solinas_fold_sum.sv
`timescale 1ns/100ps
`include "solinas_cfg.svh"

module solinas_fold_sum (
  input  logic                 clk,
  input  solinas_pkg::psum_t   psum_i,
  output solinas_pkg::sum_t    sum_o
);

  localparam int S1    = `SOLINAS_MOD_W - `SOLINAS_POW_LO;
  localparam int F_W   = `SOLINAS_MOD_W + 1;
  localparam int LO_W  = `SOLINAS_MOD_W + 2;
  localparam int SUM_W = `SOLINAS_SUM_W;

  // ----------------------------------------
  // Deferred additions
  // ----------------------------------------
  // Full stride partial sum, at most 33 bits
  logic [F_W-1:0] fold_f;

  assign fold_f = F_W'(psum_i.fold_c1) + F_W'(psum_i.fold_hi);

  // Second fold at 2^10, low bits of c1 only
  logic [LO_W-1:0] a_plus_c;

  assign a_plus_c = psum_i.lo_fold
                  + LO_W'({psum_i.fold_c1[S1-1:0], {`SOLINAS_POW_LO{1'b0}}});

  // ----------------------------------------
  // Signed fold
  // ----------------------------------------
  // wrap * 2^32 = wrap * (2^21 + 2^10 - 1)
  // Result lies between -2M and 4M
  logic [SUM_W-1:0] sum_d;

  assign sum_d = SUM_W'(a_plus_c)
               + SUM_W'({psum_i.wrap, {`SOLINAS_POW_HI{1'b0}}})
               + SUM_W'({psum_i.wrap, {`SOLINAS_POW_LO{1'b0}}})
               - SUM_W'(fold_f)
               - SUM_W'(psum_i.wrap);

  // Stage register
  solinas_pkg::sum_t sum_q;

  always_ff @(posedge clk) begin
    sum_q <= sum_d;
  end

  assign sum_o = sum_q;

endmodule

//--- design/solinas_mod_correct.sv
`timescale 1ns/100ps
`include "solinas_cfg.svh"

module solinas_mod_correct (
  input  logic                 clk,
  input  solinas_pkg::sum_t    sum_i,
  output solinas_pkg::res_t    z_o
);

  localparam int SUM_W = `SOLINAS_SUM_W;
  localparam int MOD_W = `SOLINAS_MOD_W;

  // M and 2M at the sum width
  localparam logic [SUM_W-1:0] MOD_X1 = SUM_W'(`SOLINAS_MOD_M);
  localparam logic [SUM_W-1:0] MOD_X2 = MOD_X1 << 1;

  // ----------------------------------------
  // Step one, +/- 2M
  // ----------------------------------------
  // Negative sum is at least -2M, so +2M lands in [0, 2M)
  // A sum at or above 2^32 minus 2M lands in (-M, 2M)
  logic             sum_neg;
  logic             sum_big;
  logic [SUM_W-1:0] corr2;

  assign sum_neg = sum_i[SUM_W-1];
  // Sign bit checked first, the upper bits are also set when negative
  assign sum_big = |sum_i[SUM_W-2:MOD_W];

  always_comb begin
    if (sum_neg) begin
      corr2 = sum_i + MOD_X2;
    end else if (sum_big) begin
      corr2 = sum_i - MOD_X2;
    end else begin
      corr2 = sum_i;
    end
  end

  solinas_pkg::sum_t mid_q;

  always_ff @(posedge clk) begin
    mid_q <= corr2;
  end

  // ----------------------------------------
  // Step two, +/- M
  // ----------------------------------------
  logic             mid_neg;
  logic [SUM_W-1:0] corr1;
  solinas_pkg::res_t res_d;

  assign mid_neg = mid_q[SUM_W-1];
  assign corr1   = mid_neg ? mid_q + MOD_X1 : mid_q - MOD_X1;

  // Keep mid when it was already below M
  always_comb begin
    if (mid_neg || !corr1[SUM_W-1]) begin
      res_d = corr1[MOD_W-1:0];
    end else begin
      res_d = mid_q[MOD_W-1:0];
    end
  end

  // Output register
  solinas_pkg::res_t z_q;

  always_ff @(posedge clk) begin
    z_q <= res_d;
  end

  assign z_o = z_q;

endmodule

//--- design/solinas_partial_sum.sv
`timescale 1ns/100ps
`include "solinas_cfg.svh"

module solinas_partial_sum (
  input  logic                 clk,
  input  solinas_pkg::op_t     op_i,
  output solinas_pkg::psum_t   psum_o
);

  // Strides between each inner power and MOD_W
  localparam int S0 = `SOLINAS_MOD_W - `SOLINAS_POW_HI;
  localparam int S1 = `SOLINAS_MOD_W - `SOLINAS_POW_LO;
  // Slice positions at 32, 43 and 54
  localparam int P0 = `SOLINAS_MOD_W;
  localparam int P1 = P0 + S0;
  localparam int P2 = P0 + S1;
  localparam int TOP = `SOLINAS_OP_W - 1;
  // Partial sums carry two extra bits
  localparam int C0_W = S0 + 2;
  localparam int C1_W = S1 + 2;
  localparam int LO_W = `SOLINAS_MOD_W + 2;

  // ----------------------------------------
  // Input register
  // ----------------------------------------
  solinas_pkg::op_t op_q;

  always_ff @(posedge clk) begin
    op_q <= op_i;
  end

  // ----------------------------------------
  // Slices of the upper part
  // ----------------------------------------
  // 2^32 = 2^21 + 2^10 - 1 (mod M) is applied again on every
  // part that spills above bit 32. Positions 32, 43, 54, 54
  //   c0 = a[42:32] + a[53:43] + a[64:54] + a[64:54] - a[64]
  //   c1 = a[53:32] + a[64:43] + a[64:54] + a[64:54] - a[64]
  //   c2 = a[63:32] + a[64:43] + a[64:54] + a[64:54] - a[64]
  // c1 and c2 grow out of c0 with the wider windows
  logic [S0-1:0] sl_a;
  logic [S0-1:0] sl_b;
  logic [S0-1:0] sl_c;
  logic [P0+`SOLINAS_MOD_W-P2-1:0] sl_hi;

  assign sl_a  = op_q[P1-1:P0];
  assign sl_b  = op_q[P2-1:P1];
  assign sl_c  = op_q[TOP:P2];
  // Upper part of the 32-bit window at position 32
  assign sl_hi = op_q[P0+`SOLINAS_MOD_W-1:P2];

  // ----------------------------------------
  // Partial sums
  // ----------------------------------------
  logic [C0_W-1:0]  c0;
  logic [C0_W-1:0]  c1_part;
  logic [C1_W-1:0]  c1;

  // Top bit subtracted once from every partial sum
  // No underflow since a[64] set means a[64:54] is at least 1024
  assign c0 = C0_W'(sl_a) + C0_W'(sl_b) + C0_W'(sl_c) + C0_W'(sl_c)
            - C0_W'(op_q[TOP]);

  // Window bits 11 to 21 of the positions 32 and 43
  assign c1_part = C0_W'(sl_b) + C0_W'(sl_c);
  assign c1      = C1_W'(c0) + (C1_W'(c1_part) << S0);

  // ----------------------------------------
  // Carry wrap
  // ----------------------------------------
  // Bits above the stride weigh 2^32 once shifted and fold back
  logic [`SOLINAS_WRAP_W-1:0] wrap;

  assign wrap = `SOLINAS_WRAP_W'(c0[C0_W-1:S0]) + `SOLINAS_WRAP_W'(c1[C1_W-1:S1]);

  // Low word plus the first fold
  // The 2^10 fold is added in the next stage
  logic [LO_W-1:0] lo_fold;

  assign lo_fold = LO_W'(op_q[`SOLINAS_MOD_W-1:0])
                 + LO_W'({c0[S0-1:0], {`SOLINAS_POW_HI{1'b0}}});

  // ----------------------------------------
  // First stage register
  // ----------------------------------------
  solinas_pkg::psum_t psum_d;
  solinas_pkg::psum_t psum_q;

  always_comb begin
    psum_d.lo_fold = lo_fold;
    psum_d.wrap    = wrap;
    psum_d.fold_c1 = c1;
    // Full stride sum is c1 plus this term
    psum_d.fold_hi = {sl_hi, {S1{1'b0}}};
  end

  always_ff @(posedge clk) begin
    psum_q <= psum_d;
  end

  assign psum_o = psum_q;

endmodule

//--- design/solinas_pkg.sv
`include "solinas_cfg.svh"

package solinas_pkg;

  // ----------------------------------------
  // Scalar vectors
  // ----------------------------------------

  // Operand, up to 2*MOD_W+1 bits
  typedef logic [`SOLINAS_OP_W-1:0] op_t;

  // Residue in 0 to M-1
  typedef logic [`SOLINAS_MOD_W-1:0] res_t;

  typedef logic [`SOLINAS_SIDE_W-1:0] side_t;

  // Two's complement intermediate sum
  typedef logic signed [`SOLINAS_SUM_W-1:0] sum_t;

  // ----------------------------------------
  // Request and response
  // ----------------------------------------

  typedef struct packed {
    logic  avail;
    side_t side;
    op_t   op;
  } red_req_t;

  typedef struct packed {
    logic  avail;
    side_t side;
    res_t  z;
  } red_rsp_t;

  // Control part only, goes through the delay line
  typedef struct packed {
    logic  avail;
    side_t side;
  } tag_t;

  // ----------------------------------------
  // First stage results
  // ----------------------------------------

  typedef struct packed {
    // Low word plus 2^21 fold, two carry bits on top
    logic [`SOLINAS_MOD_W+1:0]                  lo_fold;
    // Carries of both inner partial sums
    logic [`SOLINAS_WRAP_W-1:0]                 wrap;
    // Partial sum at stride 22, still with its carries
    logic [`SOLINAS_MOD_W-`SOLINAS_POW_LO+1:0]  fold_c1;
    // Remaining slice of the full stride sum, already shifted
    logic [`SOLINAS_MOD_W-1:0]                  fold_hi;
  } psum_t;

endpackage

//--- design/solinas_reduct.sv
`timescale 1ns/100ps
`include "solinas_cfg.svh"

module solinas_reduct (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  solinas_pkg::red_req_t  req_i,
  output solinas_pkg::red_rsp_t  rsp_o
);

  // ----------------------------------------
  // Data path, 2 + 1 + 2 cycles
  // ----------------------------------------
  solinas_pkg::psum_t psum;
  solinas_pkg::sum_t  fold_sum;
  solinas_pkg::res_t  z;

  // Input register and slice partial sums
  solinas_partial_sum u_partial_sum (
    .clk    (clk),
    .op_i   (req_i.op),
    .psum_o (psum)
  );

  // Single signed sum
  solinas_fold_sum u_fold_sum (
    .clk    (clk),
    .psum_i (psum),
    .sum_o  (fold_sum)
  );

  // Correction into 0 to M-1, output register
  solinas_mod_correct u_mod_correct (
    .clk   (clk),
    .sum_i (fold_sum),
    .z_o   (z)
  );

  // ----------------------------------------
  // Strobe and side tag
  // ----------------------------------------
  solinas_pkg::tag_t tag_in;
  solinas_pkg::tag_t tag_out;

  assign tag_in.avail = req_i.avail;
  assign tag_in.side  = req_i.side;

  // Same latency as the data path
  side_delay_line #(
    .payload_t (solinas_pkg::tag_t),
    .DEPTH     (`SOLINAS_LATENCY)
  ) u_side_delay (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .in_i    (tag_in),
    .out_o   (tag_out)
  );

  assign rsp_o.avail = tag_out.avail;
  assign rsp_o.side  = tag_out.side;
  assign rsp_o.z     = z;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=sim_solinas_reduct

verilator --binary --timing --assert \
  --top-module tb_solinas_reduct \
  -f solinas_reduct.f \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

//--- solinas_reduct.f
+incdir+design
+incdir+test
design/solinas_pkg.sv
design/side_delay_line.sv
design/solinas_partial_sum.sv
design/solinas_fold_sum.sv
design/solinas_mod_correct.sv
design/solinas_reduct.sv
test/tb_solinas_reduct.sv

//--- test/tb_solinas_model.svh
`ifndef TB_SOLINAS_MODEL_SVH
`define TB_SOLINAS_MODEL_SVH

// One result still owed by the DUT
typedef struct packed {
  solinas_pkg::op_t   op;
  solinas_pkg::side_t side;
  solinas_pkg::res_t  z;
} exp_t;

// Owed results in input order, popped when the output strobe fires
exp_t exp_q[$];

// Reference residue, plain division at 128 bits
function automatic solinas_pkg::res_t expected_mod(input solinas_pkg::op_t op);
  logic [127:0] wide;
  wide = 128'(op) % 128'(`SOLINAS_MOD_M);
  return solinas_pkg::res_t'(wide);
endfunction

function automatic void push_expected(input solinas_pkg::op_t op,
                                      input solinas_pkg::side_t tag);
  exp_t item;
  item.op   = op;
  item.side = tag;
  item.z    = expected_mod(op);
  exp_q.push_back(item);
endfunction

// Full 65-bit random operand
function automatic solinas_pkg::op_t rand_op();
  return solinas_pkg::op_t'({$urandom, $urandom, $urandom});
endfunction

// Residue below M; mode 0 near zero, mode 1 near M, else uniform
function automatic logic [63:0] pick_res(input int mode);
  if (mode == 0) begin
    return 64'($urandom % 16);
  end else if (mode == 1) begin
    return 64'(`SOLINAS_MOD_M - 1 - ($urandom % 16));
  end
  return 64'($urandom % `SOLINAS_MOD_M);
endfunction

// a*b + c*d, the multiply-accumulate workload
function automatic solinas_pkg::op_t prod_sum(input logic [63:0] a, input logic [63:0] b,
                                              input logic [63:0] c, input logic [63:0] d);
  return solinas_pkg::op_t'(a * b) + solinas_pkg::op_t'(c * d);
endfunction

`endif

//--- test/tb_solinas_reduct.sv
`timescale 1ns/100ps
`include "solinas_cfg.svh"

module tb_solinas_reduct;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYC    = 8;
  localparam int LAT        = `SOLINAS_LATENCY;
  localparam int N_RAND     = 200;
  localparam int N_SIDE     = 60;
  localparam int N_PROD     = 64;
  // Stimulus with gaps of up to 3 per tagged item plus drains and slack
  localparam int MAX_CYC = RST_CYC + 20 + N_RAND + 4 * N_SIDE + N_PROD + 5 * (LAT + 4) + 100;

  logic                  clk;
  logic                  rst_n;
  solinas_pkg::red_req_t req;
  solinas_pkg::red_rsp_t rsp;

  int cyc = 0;
  int asrt_errs = 0;
  int val_errs = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  `include "tb_solinas_model.svh"

  exp_t head;

  solinas_reduct dut_i (
    .clk     (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Strobe low in reset and while the pipeline refills
  reset_quiet: assert property (@(posedge clk)
      (cyc >= 1 && cyc <= RST_CYC + LAT) |-> !rsp.avail)
    else begin
      asrt_errs++;
      $display("Fail %0t: output avail high during reset or refill", $time);
    end

  // Output strobe is the input strobe five edges later
  avail_delay: assert property (@(posedge clk)
      (cyc > RST_CYC + LAT) |-> (rsp.avail == $past(req.avail, LAT)))
    else begin
      asrt_errs++;
      $display("Fail %0t: output avail does not follow input avail", $time);
    end

  side_delay: assert property (@(posedge clk)
      (cyc > RST_CYC + LAT && rsp.avail) |-> (rsp.side == $past(req.side, LAT)))
    else begin
      asrt_errs++;
      $display("Fail %0t: side tag 0x%h not the one sent", $time, rsp.side);
    end

  z_range: assert property (@(posedge clk) rsp.avail |-> (rsp.z < `SOLINAS_MOD_M))
    else begin
      asrt_errs++;
      $display("Fail %0t: residue 0x%h not below M", $time, rsp.z);
    end

  // Value check against the model at the falling edge
  always @(negedge clk) begin
    if (rsp.avail) begin
      result_owed: assert (exp_q.size() != 0)
        else begin
          val_errs++;
          $display("Output avail high at %0t with no operand waiting for a result", $time);
        end
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        value_check: assert (rsp.z == head.z && rsp.side == head.side)
          else begin
            val_errs++;
            $display("Fail %0t: op 0x%h gave z 0x%h tag 0x%h, expected z 0x%h tag 0x%h",
                     $time, head.op, rsp.z, rsp.side, head.z, head.side);
          end
      end
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic drive_item(input solinas_pkg::op_t op, input solinas_pkg::side_t tag);
    @(posedge clk);
    req <= '{1'b1, tag, op};
    push_expected(op, tag);
  endtask

  // Strobe low with a random operand
  task automatic drive_idle();
    @(posedge clk);
    req.avail <= 1'b0;
    req.op    <= rand_op();
  endtask

  task automatic wait_drain();
    drive_idle();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = asrt_errs + val_errs - errs_before;
    if (errs == 0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int base;
    int gap;
    solinas_pkg::op_t m;
    solinas_pkg::op_t mult;
    req      = '0;
    rst_n    = 1'b0;
    void'($urandom(82));
    m        = solinas_pkg::op_t'(`SOLINAS_MOD_M);

    // Reset held while the strobe is driven high
    base = asrt_errs + val_errs;
    repeat (RST_CYC - 1) begin
      @(posedge clk);
      req <= '{1'b1, solinas_pkg::side_t'($urandom), rand_op()};
    end
    @(posedge clk);
    rst_n     <= 1'b1;
    req.avail <= 1'b0;
    while (cyc <= RST_CYC + LAT) @(posedge clk);
    report_test("reset", base);

    // Edge operands
    base = asrt_errs + val_errs;
    drive_item('0, 8'hE0);
    drive_item(m - solinas_pkg::op_t'(1), 8'hE1);
    drive_item(m, 8'hE2);
    drive_item(m + m, 8'hE3);
    drive_item(solinas_pkg::op_t'(32'hFFFF_FFFF), 8'hE4);
    drive_item({1'b0, {64{1'b1}}}, 8'hE5);
    drive_item('1, 8'hE6);
    drive_item((solinas_pkg::op_t'('1) / m) * m, 8'hE7);
    // Multiples of M with offsets -1, 0 and +1
    for (int k = 0; k < 9; k++) begin
      mult = solinas_pkg::op_t'(k + 1) << (3 * k);
      drive_item(m * mult + solinas_pkg::op_t'(k % 3) - solinas_pkg::op_t'(1),
                 solinas_pkg::side_t'(k));
    end
    wait_drain();
    report_test("edge", base);

    // Back to back random operands
    base = asrt_errs + val_errs;
    for (int i = 0; i < N_RAND; i++) begin
      drive_item(rand_op(), solinas_pkg::side_t'(i));
    end
    wait_drain();
    report_test("random", base);

    // Random tags with random gaps in the strobe
    base = asrt_errs + val_errs;
    for (int i = 0; i < N_SIDE; i++) begin
      gap = $urandom % 4;
      repeat (gap) drive_idle();
      drive_item(rand_op(), solinas_pkg::side_t'($urandom));
    end
    wait_drain();
    report_test("side", base);

    // Sums of two products near the bottom, top and middle of the range
    base = asrt_errs + val_errs;
    drive_item(prod_sum(pick_res(1), pick_res(1), pick_res(1), pick_res(1)), 8'hF0);
    for (int i = 0; i < N_PROD; i++) begin
      drive_item(prod_sum(pick_res(i % 3), pick_res(i % 3), pick_res((i + 1) % 3),
                          pick_res(i % 3)), solinas_pkg::side_t'(i));
    end
    wait_drain();
    report_test("product", base);

    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_ok + tests_bad, tests_ok, tests_bad, asrt_errs + val_errs);
    if (tests_bad == 0 && asrt_errs + val_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(MAX_CYC * CLK_PERIOD);
    $display("Watchdog: run still busy after %0d cycles, stopping", MAX_CYC);
    $display("tests failed");
    $finish;
  end

endmodule
